// ==== tx_filter_pkg.sv ====
`default_nettype none

package tx_filter_pkg;

	// Word widths
	localparam int SAMPLE_W  = 18;
	localparam int PAIR_W    = SAMPLE_W + 1;
	localparam int PRODUCT_W = 18;

	// Filter length and folding
	localparam int COEFF_LEN = 65;
	localparam int HALF_LEN  = (COEFF_LEN - 1) / 2;

	// 1s17 input and output samples
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// 2s17 sum of two facing taps
	typedef logic signed [PAIR_W-1:0] pair_sum_t;

	// 1s17 coefficient product
	typedef logic signed [PRODUCT_W-1:0] product_t;

	// Quarter-scale step, so the PAM levels are +-1 and +-3 steps
	localparam int LEVEL_STEP = 32768;

	// Keys k * LEVEL_STEP for k = 1 .. NUM_LEVELS
	localparam int NUM_LEVELS = 6;

	// Products per tap, column k-1 holds the result for key k * LEVEL_STEP
	// Two legal symbols never sum to 5 steps, so that column stays zero
	// The centre tap only ever sees a single symbol, so only k = 1 and 3 are set
	localparam product_t TAP_PRODUCTS [0:HALF_LEN][0:NUM_LEVELS-1] = '{
		// Taps 0 to 7
		'{   168,    337,    505,    673, 0,   1010},
		'{    69,    138,    207,    276, 0,    413},
		'{  -108,   -216,   -325,   -433, 0,   -649},
		'{  -243,   -487,   -730,   -973, 0,  -1460},
		'{  -224,   -448,   -671,   -895, 0,  -1343},
		'{   -31,    -62,    -92,   -123, 0,   -185},
		'{   229,    457,    686,    915, 0,   1372},
		'{   376,    753,   1129,   1505, 0,   2258},

		// Taps 8 to 15
		'{   280,    560,    840,   1121, 0,   1681},
		'{   -41,    -82,   -122,   -163, 0,   -245},
		'{  -401,   -801,  -1202,  -1602, 0,  -2403},
		'{  -548,  -1096,  -1644,  -2193, 0,  -3289},
		'{  -335,   -669,  -1004,  -1338, 0,  -2008},
		'{   162,    324,    485,    647, 0,    971},
		'{   647,   1294,   1941,   2588, 0,   3882},
		'{   776,   1552,   2328,   3104, 0,   4655},

		// Taps 16 to 23
		'{   384,    768,   1153,   1537, 0,   2305},
		'{  -362,   -725,  -1087,  -1450, 0,  -2175},
		'{ -1017,  -2034,  -3050,  -4067, 0,  -6101},
		'{ -1101,  -2201,  -3302,  -4402, 0,  -6604},
		'{  -426,   -852,  -1278,  -1704, 0,  -2557},
		'{   714,   1428,   2143,   2857, 0,   4285},
		'{  1638,   3276,   4915,   6553, 0,   9829},
		'{  1641,   3282,   4923,   6565, 0,   9847},

		// Taps 24 to 31, the main lobe builds up here
		'{   458,    916,   1374,   1832, 0,   2748},
		'{ -1450,  -2899,  -4349,  -5798, 0,  -8697},
		'{ -2986,  -5972,  -8959, -11945, 0, -17917},
		'{ -2908,  -5815,  -8723, -11630, 0, -17446},
		'{  -478,   -956,  -1434,  -1911, 0,  -2867},
		'{  4042,   8084,  12126,  16167, 0,  24251},
		'{  9358,  18717,  28075,  37434, 0,  56151},
		'{ 13631,  27262,  40893,  54524, 0,  81786},

		// Centre tap
		'{ 15265,      0,  45794,      0, 0,      0}
	};

endpackage

`default_nettype wire

// ==== sample_delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_delay_line
(
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    sam_clk_en,
	input  tx_filter_pkg::sample_t       x_in,
	output tx_filter_pkg::pair_sum_t     pair_sum [0:tx_filter_pkg::HALF_LEN]
);

	import tx_filter_pkg::*;

	// Tap 0 is the newest sample
	sample_t taps [0:COEFF_LEN-1];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < COEFF_LEN; i++)
			begin
				taps[i] <= '0;
			end
		end
		else if (sam_clk_en)
		begin
			taps[0] <= x_in;
			for (int i = 1; i < COEFF_LEN; i++)
			begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// Facing taps share a coefficient, so add them before the lookup
	always_comb
	begin
		for (int i = 0; i < HALF_LEN; i++)
		begin
			pair_sum[i] = pair_sum_t'(taps[i]) + pair_sum_t'(taps[COEFF_LEN-1-i]);
		end
		// Centre tap has no partner
		pair_sum[HALF_LEN] = pair_sum_t'(taps[HALF_LEN]);
	end

endmodule

`default_nettype wire

// ==== tap_product_lut.sv ====
`timescale 1ns/1ps
`default_nettype none

module tap_product_lut
#(
	parameter int TAP = 0
)
(
	input  tx_filter_pkg::pair_sum_t pair_sum,
	output tx_filter_pkg::product_t  product
);

	import tx_filter_pkg::*;

	// One hit bit per positive and negative key
	logic [NUM_LEVELS-1:0] pos_hit;
	logic [NUM_LEVELS-1:0] neg_hit;

	genvar k;
	generate
		for (k = 0; k < NUM_LEVELS; k++)
		begin : g_key
			localparam pair_sum_t POS_KEY = pair_sum_t'((k + 1) * LEVEL_STEP);
			localparam pair_sum_t NEG_KEY = pair_sum_t'(-(k + 1) * LEVEL_STEP);

			assign pos_hit[k] = (pair_sum == POS_KEY);
			assign neg_hit[k] = (pair_sum == NEG_KEY);
		end
	endgenerate

	// At most one key can match, anything else reads as zero
	always_comb
	begin
		product = '0;
		for (int i = 0; i < NUM_LEVELS; i++)
		begin
			if (pos_hit[i])
			begin
				product = TAP_PRODUCTS[TAP][i];
			end
			else if (neg_hit[i])
			begin
				product = -TAP_PRODUCTS[TAP][i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== product_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module product_accumulator
(
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                sam_clk_en,
	input  tx_filter_pkg::product_t  product [0:tx_filter_pkg::HALF_LEN],
	output tx_filter_pkg::sample_t   y
);

	import tx_filter_pkg::*;

	// Running sum, wraps at 18 bits
	product_t chain [0:HALF_LEN];

	always_comb
	begin
		chain[0] = product[0];
		for (int i = 1; i <= HALF_LEN; i++)
		begin
			chain[i] = chain[i-1] + product[i];
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			y <= '0;
		end
		else if (sam_clk_en)
		begin
			y <= sample_t'(chain[HALF_LEN]);
		end
	end

endmodule

`default_nettype wire

// ==== pract_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pract_filter
(
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              sam_clk_en,
	input  tx_filter_pkg::sample_t x_in,
	output tx_filter_pkg::sample_t y
);

	import tx_filter_pkg::*;

	pair_sum_t pair_sum [0:HALF_LEN];
	product_t  product  [0:HALF_LEN];

	sample_delay_line u_delay_line
	(
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.x_in       (x_in),
		.pair_sum   (pair_sum)
	);

	// One lookup per folded pair plus the centre
	genvar t;
	generate
		for (t = 0; t <= HALF_LEN; t++)
		begin : g_tap
			tap_product_lut #(
				.TAP (t)
			) u_lut
			(
				.pair_sum (pair_sum[t]),
				.product  (product[t])
			);
		end
	endgenerate

	product_accumulator u_accumulator
	(
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.product    (product),
		.y          (y)
	);

endmodule

`default_nettype wire

// ==== tb_pract_filter_vectors.svh ====
`ifndef TB_PRACT_FILTER_VECTORS_SVH
`define TB_PRACT_FILTER_VECTORS_SVH

	// Columns: test, x_in, sam_clk_en, repeat count, kind of check, expected y
	// A row with a repeat count is applied on that many consecutive cycles
	task automatic load_vectors();
		// Test 1, zero samples keep y at zero
		add_row(1,      0, 1,   4, KIND_VALUE,    0);
		// A sample without a strobe never enters the line
		add_row(1,  98304, 0,   3, KIND_VALUE,    0);
		add_row(1,      0, 1,   3, KIND_VALUE,    0);
		add_row(1, -32768, 0,   2, KIND_VALUE,    0);
		add_row(1,      0, 1,   2, KIND_VALUE,    0);

		// Test 2, impulses walk through every tap and back out
		add_row(2,  98304, 1,   1, KIND_PULSE,    0);
		add_row(2,      0, 1,  66, KIND_PULSE,    0);
		add_row(2, -32768, 1,   1, KIND_PULSE,    0);
		add_row(2,      0, 1,  66, KIND_PULSE,    0);

		// Test 3, idle cycles with a changing input are ignored
		add_row(3,  98304, 1,   1, KIND_VALUE,    0);
		add_row(3, -98304, 0,   3, KIND_VALUE,    0);
		// Tap 0 key 3
		add_row(3,  32768, 1,   1, KIND_VALUE,  505);
		add_row(3,   1234, 0,   4, KIND_VALUE,  505);
		// Tap 0 key 1 plus tap 1 key 3
		add_row(3, -32768, 1,   1, KIND_VALUE,  375);
		add_row(3,  98304, 0,   2, KIND_VALUE,  375);
		// Tap 0 key -1, tap 1 key 1, tap 2 key 3
		add_row(3,      0, 1,   1, KIND_VALUE, -424);
		add_row(3,  65536, 0,   5, KIND_VALUE, -424);
		add_row(3,      0, 1,  30, KIND_MODEL,    0);
		add_row(3,  32768, 0,   3, KIND_MODEL,    0);
		add_row(3,      0, 1,  40, KIND_MODEL,    0);

		// Test 4, random legal symbols on back to back strobes
		add_row(4,      0, 1, 300, KIND_RANDOM,   0);
		add_row(4,      0, 1,  66, KIND_MODEL,    0);

		// Test 5, a value off the PAM grid finds no key
		add_row(5,   1000, 1,   1, KIND_VALUE,    0);
		add_row(5,      0, 1,   1, KIND_VALUE,    0);
		add_row(5,  32768, 1,   1, KIND_VALUE,    0);
		// Only the legal symbol in tap 0 adds a product
		add_row(5,      0, 1,   1, KIND_VALUE,  168);
		add_row(5,      0, 1,  66, KIND_MODEL,    0);

		// Two half steps facing each other sum to a valid key
		add_row(5,  16384, 1,   1, KIND_MODEL,    0);
		add_row(5,      0, 1,  63, KIND_MODEL,    0);
		add_row(5,  16384, 1,   1, KIND_VALUE,    0);
		add_row(5,      0, 1,   1, KIND_VALUE,  168);
		add_row(5,      0, 1,  66, KIND_MODEL,    0);

		// Illegal values mixed with legal symbols
		add_row(5,  -1000, 1,   1, KIND_MODEL,    0);
		add_row(5,  98304, 1,   1, KIND_MODEL,    0);
		add_row(5,  33768, 1,   1, KIND_MODEL,    0);
		add_row(5,      0, 1,  70, KIND_MODEL,    0);
	endtask

`endif

// ==== tb_pract_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pract_filter;

	import tx_filter_pkg::*;

	localparam int HALF_PERIOD   = 50;
	localparam int RESET_CYCLES  = 4;
	localparam int EDGE_TIMEOUT  = 500;
	localparam int RESET_TIMEOUT = 20;

	// Kinds of expected value in the vector table
	localparam int KIND_VALUE  = 0;
	localparam int KIND_MODEL  = 1;
	localparam int KIND_PULSE  = 2;
	localparam int KIND_RANDOM = 3;

	logic    clk;
	logic    reset;
	logic    sam_clk_en;
	sample_t x_in;
	sample_t y;

	// Vector table columns as parallel queues
	int row_test[$];
	int row_sample[$];
	int row_strobe[$];
	int row_reps[$];
	int row_kind[$];
	int row_value[$];

	// Reference line with the newest sample at index 0
	int model_line [0:COEFF_LEN-1];
	int model_y;
	int pulse_amp;
	int pulse_age;
	// Pair sum hits per key k at index k + NUM_LEVELS
	int key_seen [0:2*NUM_LEVELS];

	int cycle_count = 0;
	int check_count;
	int error_count;
	int test_checks;
	int test_errors;

	pract_filter DUT
	(
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.x_in       (x_in),
		.y          (y)
	);

	task automatic add_row(input int test, input int sample, input int strobe,
		input int reps, input int kind, input int value);
		row_test.push_back(test);
		row_sample.push_back(sample);
		row_strobe.push_back(strobe);
		row_reps.push_back(reps);
		row_kind.push_back(kind);
		row_value.push_back(value);
	endtask

	`include "tb_pract_filter_vectors.svh"

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#HALF_PERIOD clk = ~clk;
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
	end

	// Returns 1 ns after the next rising edge
	task automatic wait_clock_edge();
		int target;
		int waited;
		target = cycle_count + 1;
		waited = 0;
		while (cycle_count < target && waited < EDGE_TIMEOUT)
		begin
			#1;
			waited++;
		end
		if (cycle_count < target)
		begin
			$display("Timeout: no rising clock edge seen within %0d ns at %0t",
				EDGE_TIMEOUT, $time);
			$display("Done: errors found");
			$finish;
		end
	endtask

	initial
	begin
		reset = 1'b1;
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			wait_clock_edge();
		end
		reset <= 1'b0;
	end

	function automatic int wrap_18(input int value);
		int low;
		low = value & 32'h3FFFF;
		if (low >= 32'h20000)
		begin
			low = low - 32'h40000;
		end
		return low;
	endfunction

	// Product of one tap for a pair sum or zero when the sum is no table key
	function automatic int model_product(input int tap, input int pair);
		int mag;
		int k;
		int entry;
		mag = (pair < 0) ? -pair : pair;
		k = mag / LEVEL_STEP;
		if (mag % LEVEL_STEP != 0 || k < 1 || k > NUM_LEVELS)
		begin
			return 0;
		end
		entry = TAP_PRODUCTS[tap][k-1];
		return (pair < 0) ? -entry : entry;
	endfunction

	function automatic int model_output();
		int sum;
		sum = 0;
		for (int t = 0; t < HALF_LEN; t++)
		begin
			sum += model_product(t, model_line[t] + model_line[COEFF_LEN-1-t]);
		end
		sum += model_product(HALF_LEN, model_line[HALF_LEN]);
		return wrap_18(sum);
	endfunction

	// Expected output a number of strobes after a lone symbol entered an empty line
	function automatic int pulse_response(input int amp, input int age);
		int idx;
		int entry;
		if (amp == 0 || age < 1 || age > COEFF_LEN)
		begin
			return 0;
		end
		idx = age - 1;
		if (idx > HALF_LEN)
		begin
			idx = COEFF_LEN - 1 - idx;
		end
		entry = TAP_PRODUCTS[idx][((amp < 0) ? -amp : amp) / LEVEL_STEP - 1];
		return (amp < 0) ? -entry : entry;
	endfunction

	function automatic int pam_symbol(input int unsigned idx);
		case (idx % 4)
			0: return -98304;
			1: return -32768;
			2: return 32768;
			default: return 98304;
		endcase
	endfunction

	task automatic count_pair_keys();
		int pair;
		int k;
		for (int t = 0; t < HALF_LEN; t++)
		begin
			pair = model_line[t] + model_line[COEFF_LEN-1-t];
			k = pair / LEVEL_STEP;
			if (pair % LEVEL_STEP == 0 && k >= -NUM_LEVELS && k <= NUM_LEVELS)
			begin
				key_seen[k + NUM_LEVELS]++;
			end
		end
	endtask

	task automatic model_step(input int strobe, input int sample);
		if (strobe != 0)
		begin
			model_y = model_output();
			for (int i = COEFF_LEN - 1; i > 0; i--)
			begin
				model_line[i] = model_line[i-1];
			end
			model_line[0] = sample;
			if (sample != 0)
			begin
				pulse_amp = sample;
				pulse_age = 0;
			end
			else if (pulse_age <= COEFF_LEN)
			begin
				pulse_age++;
			end
		end
	endtask

	task automatic check_y(input int test, input int expected, input string what);
		check_count++;
		test_checks++;
		if (y !== sample_t'(expected))
		begin
			error_count++;
			test_errors++;
			$display("FAIL %0t: test %0d, %s: y = %0d, expected %0d",
				$time, test, what, y, expected);
		end
	endtask

	task automatic finish_test(input int test);
		if (test == 4)
		begin
			for (int k = 2; k <= NUM_LEVELS; k += 2)
			begin
				check_count++;
				test_checks++;
				if (key_seen[NUM_LEVELS + k] == 0 || key_seen[NUM_LEVELS - k] == 0)
				begin
					error_count++;
					test_errors++;
					$display("Random stream never formed a pair sum of plus and minus %0d",
						k * LEVEL_STEP);
				end
			end
		end
		$display("Test %0d finished: %0d checks, %0d errors", test, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	initial
	begin
		int waited;
		int sample;
		int current_test;
		sam_clk_en = 1'b0;
		x_in = '0;
		void'($urandom(32'h6189));
		for (int i = 0; i < COEFF_LEN; i++)
		begin
			model_line[i] = 0;
		end
		for (int i = 0; i <= 2 * NUM_LEVELS; i++)
		begin
			key_seen[i] = 0;
		end
		model_y = 0;
		pulse_amp = 0;
		pulse_age = COEFF_LEN + 1;
		check_count = 0;
		error_count = 0;
		test_checks = 0;
		test_errors = 0;
		load_vectors();

		// Output must stay cleared until reset is gone
		waited = 0;
		wait_clock_edge();
		while (reset === 1'b1 && waited < RESET_TIMEOUT)
		begin
			check_y(1, 0, "under reset");
			wait_clock_edge();
			waited++;
		end
		if (reset !== 1'b0)
		begin
			$display("Reset was not released within %0d cycles", RESET_TIMEOUT);
			$display("Done: errors found");
			$finish;
		end
		check_y(1, 0, "after reset");

		current_test = row_test[0];
		for (int r = 0; r < row_test.size(); r++)
		begin
			if (row_test[r] != current_test)
			begin
				finish_test(current_test);
				current_test = row_test[r];
			end
			for (int n = 0; n < row_reps[r]; n++)
			begin
				sample = row_sample[r];
				if (row_kind[r] == KIND_RANDOM)
				begin
					sample = pam_symbol($urandom);
				end
				x_in = sample_t'(sample);
				sam_clk_en = (row_strobe[r] != 0);
				wait_clock_edge();
				if (row_kind[r] == KIND_RANDOM)
				begin
					count_pair_keys();
				end
				model_step(row_strobe[r], sample);
				check_y(row_test[r], model_y, "reference model");
				if (row_kind[r] == KIND_VALUE)
				begin
					check_y(row_test[r], row_value[r], "table value");
				end
				else if (row_kind[r] == KIND_PULSE)
				begin
					check_y(row_test[r], pulse_response(pulse_amp, pulse_age), "impulse response");
				end
			end
		end
		finish_test(current_test);
		sam_clk_en = 1'b0;
		x_in = '0;

		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
		begin
			$display("Done: no errors");
		end
		else
		begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
tx_filter_pkg.sv
sample_delay_line.sv
tap_product_lut.sv
product_accumulator.sv
pract_filter.sv
tb_pract_filter.sv

// ==== Bender.yml ====
package:
  name: pract_filter

dependencies: {}

sources:
  # Filter RTL in compile order
  - files:
      - tx_filter_pkg.sv
      - sample_delay_line.sv
      - tap_product_lut.sv
      - product_accumulator.sv
      - pract_filter.sv

  # Testbench with its vector table header
  - target: test
    include_dirs:
      - .
    files:
      - tb_pract_filter.sv
